//--- logic/cachePkg.sv
// Cache memory types
package cachePkg;

	localparam int dataWidth = 16;
	localparam int bankAddrWidth = 4;
	localparam int nodeIdWidth = 4;

	typedef logic [dataWidth-1:0] word;
	typedef logic [bankAddrWidth-1:0] bankAddr;

	// Row-major node number
	typedef logic [nodeIdWidth-1:0] nodeId;

	typedef enum logic {
		opRead,
		opWrite
	} memOp;

	// What a host presents on its access port
	typedef struct packed {
		memOp op;
		nodeId node;
		logic [bankAddrWidth-1:0] bankAddr;
		word data;
	} hostRequest;

endpackage

//--- logic/meshPkg.sv
// Mesh link types
package meshPkg;

	typedef enum logic {
		kindRequest,
		kindResponse
	} flitKind;

	// Index into the four link arrays of a router
	typedef enum logic [1:0] {
		dirNorth,
		dirSouth,
		dirEast,
		dirWest
	} direction;

	// One flit per link register
	typedef struct packed {
		logic valid;
		flitKind kind;
		cachePkg::memOp op;
		cachePkg::nodeId dest;
		cachePkg::nodeId requester;
		cachePkg::bankAddr bankAddr;
		cachePkg::word data;
	} meshFlit;

endpackage

//--- logic/cacheBank.sv
// Local cache bank
`timescale 1ns/1ps

module cacheBank (
	input logic clk,
	input logic reset,
	input meshPkg::meshFlit reqFlit,
	output logic reqBusy,
	output meshPkg::meshFlit respFlit,
	input logic respBusy
);

	localparam int bankWords = 2 ** cachePkg::bankAddrWidth;

	cachePkg::word mem [bankWords];
	meshPkg::meshFlit respReg;
	cachePkg::word respData;

	// Writes echo their own data
	assign respData = (reqFlit.op == cachePkg::opWrite) ? reqFlit.data : mem[reqFlit.bankAddr];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < bankWords; i++) begin
				mem[i] <= '0;
			end
			respReg.valid <= 1'b0;
		end else begin
			if (reqFlit.valid) begin
				if (reqFlit.op == cachePkg::opWrite) begin
					mem[reqFlit.bankAddr] <= reqFlit.data;
				end
				respReg <= '{valid: 1'b1, kind: meshPkg::kindResponse, op: reqFlit.op,
					dest: reqFlit.requester, requester: reqFlit.requester,
					bankAddr: reqFlit.bankAddr, data: respData};
			end else if (!respBusy) begin
				respReg.valid <= 1'b0;
			end
		end
	end

	// No new request while a response is held
	assign reqBusy = respReg.valid;
	assign respFlit = (respReg.valid && !respBusy) ? respReg : '0;

endmodule

//--- logic/meshRouter.sv
// Mesh router
`timescale 1ns/1ps

module meshRouter #(
	parameter int networkHeight = 3,
	parameter int networkWidth = 3,
	parameter int nodeRow = 0,
	parameter int nodeCol = 0
) (
	input logic clk,
	input logic reset,
	input meshPkg::meshFlit linkIn [4],
	output logic [3:0] linkInBusy,
	output meshPkg::meshFlit linkOut [4],
	input logic [3:0] linkOutBusy,
	output meshPkg::meshFlit bankOut,
	input logic bankOutBusy,
	input meshPkg::meshFlit bankIn,
	output logic bankInBusy,
	input meshPkg::meshFlit hostIn,
	output logic hostInBusy,
	output meshPkg::meshFlit hostOut,
	input logic hostOutBusy
);

	// Ports 0 to 3 follow the direction enum
	localparam int bankPort = 4;
	localparam int hostPort = 5;
	localparam int portCount = 6;

	meshPkg::meshFlit inFlit [portCount];
	meshPkg::meshFlit inReg [portCount];
	meshPkg::meshFlit outFlit [portCount];
	logic [portCount-1:0] outBusy;
	logic [portCount-1:0] granted;
	logic [2:0] target [portCount];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			inFlit[i] = linkIn[i];
		end
		inFlit[bankPort] = bankIn;
		inFlit[hostPort] = hostIn;
		outBusy = {hostOutBusy, bankOutBusy, linkOutBusy};
	end

	// Input registers
	always_ff @(posedge clk) begin
		for (int i = 0; i < portCount; i++) begin
			if (reset) begin
				inReg[i].valid <= 1'b0;
			end else if (inFlit[i].valid) begin
				inReg[i] <= inFlit[i];
			end else if (granted[i]) begin
				inReg[i].valid <= 1'b0;
			end
		end
	end

	// Senders hold off while a register is full
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			linkInBusy[i] = inReg[i].valid;
		end
		bankInBusy = inReg[bankPort].valid;
		hostInBusy = inReg[hostPort].valid;
	end

	// XY routing, column before row
	always_comb begin
		int destRow;
		int destCol;
		for (int i = 0; i < portCount; i++) begin
			destRow = int'(inReg[i].dest) / networkWidth;
			destCol = int'(inReg[i].dest) % networkWidth;
			if (destCol > nodeCol) begin
				target[i] = 3'(meshPkg::dirEast);
			end else if (destCol < nodeCol) begin
				target[i] = 3'(meshPkg::dirWest);
			end else if (destRow > nodeRow) begin
				target[i] = 3'(meshPkg::dirSouth);
			end else if (destRow < nodeRow) begin
				target[i] = 3'(meshPkg::dirNorth);
			end else if (inReg[i].kind == meshPkg::kindRequest) begin
				target[i] = 3'(bankPort);
			end else begin
				target[i] = 3'(hostPort);
			end
		end
	end

	// Fixed priority per output, lowest input index wins
	always_comb begin
		logic found;
		granted = '0;
		for (int o = 0; o < portCount; o++) begin
			found = 1'b0;
			outFlit[o] = '0;
			for (int i = 0; i < portCount; i++) begin
				if (!found && !outBusy[o] && inReg[i].valid && target[i] == 3'(o)) begin
					found = 1'b1;
					granted[i] = 1'b1;
					outFlit[o] = inReg[i];
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			linkOut[i] = outFlit[i];
		end
		bankOut = outFlit[bankPort];
		hostOut = outFlit[hostPort];
	end

endmodule

//--- logic/accessPort.sv
// Host access port
`timescale 1ns/1ps

module accessPort #(
	parameter int localNode = 0
) (
	input logic clk,
	input logic reset,
	input logic req,
	input cachePkg::hostRequest request,
	output logic ack,
	output cachePkg::word readData,
	output meshPkg::meshFlit injectFlit,
	input logic injectBusy,
	input meshPkg::meshFlit responseFlit,
	output logic responseBusy
);

	typedef enum logic [1:0] {
		portIdle,
		portInject,
		portWait,
		portAck
	} portState;

	portState state;
	meshPkg::meshFlit requestFlit;
	logic responseSeen;

	// Host keeps request stable while req is high
	always_comb begin
		requestFlit = '{valid: 1'b1, kind: meshPkg::kindRequest, op: request.op,
			dest: request.node, requester: cachePkg::nodeId'(localNode),
			bankAddr: request.bankAddr, data: request.data};
	end

	assign injectFlit = (state == portInject && !injectBusy) ? requestFlit : '0;

	// Only our own response can arrive here
	assign responseBusy = 1'b0;
	assign responseSeen = responseFlit.valid && responseFlit.kind == meshPkg::kindResponse;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= portIdle;
			readData <= '0;
		end else begin
			case (state)
				portIdle: begin
					if (req) begin
						state <= portInject;
					end
				end
				portInject: begin
					if (!injectBusy) begin
						state <= portWait;
					end
				end
				portWait: begin
					if (responseSeen) begin
						readData <= responseFlit.data;
						state <= portAck;
					end
				end
				portAck: begin
					// Release after the host drops req
					if (!req) begin
						state <= portIdle;
					end
				end
				default: state <= portIdle;
			endcase
		end
	end

	assign ack = (state == portAck);

endmodule

//--- logic/meshNetwork.sv
// Cache mesh top level
`timescale 1ns/1ps

module meshNetwork #(
	parameter int networkHeight = 3,
	parameter int networkWidth = 3
) (
	input logic clk,
	input logic reset,
	input logic req0,
	input cachePkg::hostRequest request0,
	output logic ack0,
	output cachePkg::word readData0,
	input logic req1,
	input cachePkg::hostRequest request1,
	output logic ack1,
	output cachePkg::word readData1
);

	localparam int nodeCount = networkHeight * networkWidth;

	// Top-row middle and bottom-row left of middle
	localparam int port0Node = networkWidth / 2;
	localparam int port1Node = (networkHeight - 1) * networkWidth + networkWidth / 2 - 1;

	wire meshPkg::meshFlit linkIn [nodeCount][4];
	meshPkg::meshFlit linkOut [nodeCount][4];
	logic [3:0] linkInBusy [nodeCount];
	wire [3:0] linkOutBusy [nodeCount];
	wire meshPkg::meshFlit hostIn [nodeCount];
	meshPkg::meshFlit hostOut [nodeCount];
	logic hostInBusy [nodeCount];
	wire hostOutBusy [nodeCount];

	for (genvar n = 0; n < nodeCount; n++) begin : node
		localparam int row = n / networkWidth;
		localparam int col = n % networkWidth;

		meshPkg::meshFlit bankReq;
		meshPkg::meshFlit bankResp;
		logic bankReqBusy;
		logic bankRespBusy;

		meshRouter #(
			.networkHeight(networkHeight),
			.networkWidth(networkWidth),
			.nodeRow(row),
			.nodeCol(col)
		) router (
			.clk(clk),
			.reset(reset),
			.linkIn(linkIn[n]),
			.linkInBusy(linkInBusy[n]),
			.linkOut(linkOut[n]),
			.linkOutBusy(linkOutBusy[n]),
			.bankOut(bankReq),
			.bankOutBusy(bankReqBusy),
			.bankIn(bankResp),
			.bankInBusy(bankRespBusy),
			.hostIn(hostIn[n]),
			.hostInBusy(hostInBusy[n]),
			.hostOut(hostOut[n]),
			.hostOutBusy(hostOutBusy[n])
		);

		cacheBank bank (
			.clk(clk),
			.reset(reset),
			.reqFlit(bankReq),
			.reqBusy(bankReqBusy),
			.respFlit(bankResp),
			.respBusy(bankRespBusy)
		);

		// Busy always comes back from the neighbor's input register
		if (row > 0) begin : northLink
			assign linkIn[n][meshPkg::dirNorth] = linkOut[n-networkWidth][meshPkg::dirSouth];
			assign linkOutBusy[n][meshPkg::dirNorth] = linkInBusy[n-networkWidth][meshPkg::dirSouth];
		end else begin : northEdge
			assign linkIn[n][meshPkg::dirNorth] = '0;
			assign linkOutBusy[n][meshPkg::dirNorth] = 1'b0;
		end

		if (row < networkHeight - 1) begin : southLink
			assign linkIn[n][meshPkg::dirSouth] = linkOut[n+networkWidth][meshPkg::dirNorth];
			assign linkOutBusy[n][meshPkg::dirSouth] = linkInBusy[n+networkWidth][meshPkg::dirNorth];
		end else begin : southEdge
			assign linkIn[n][meshPkg::dirSouth] = '0;
			assign linkOutBusy[n][meshPkg::dirSouth] = 1'b0;
		end

		if (col < networkWidth - 1) begin : eastLink
			assign linkIn[n][meshPkg::dirEast] = linkOut[n+1][meshPkg::dirWest];
			assign linkOutBusy[n][meshPkg::dirEast] = linkInBusy[n+1][meshPkg::dirWest];
		end else begin : eastEdge
			assign linkIn[n][meshPkg::dirEast] = '0;
			assign linkOutBusy[n][meshPkg::dirEast] = 1'b0;
		end

		if (col > 0) begin : westLink
			assign linkIn[n][meshPkg::dirWest] = linkOut[n-1][meshPkg::dirEast];
			assign linkOutBusy[n][meshPkg::dirWest] = linkInBusy[n-1][meshPkg::dirEast];
		end else begin : westEdge
			assign linkIn[n][meshPkg::dirWest] = '0;
			assign linkOutBusy[n][meshPkg::dirWest] = 1'b0;
		end

		// Nodes without a host
		if (n != port0Node && n != port1Node) begin : noHost
			assign hostIn[n] = '0;
			assign hostOutBusy[n] = 1'b0;
		end
	end

	accessPort #(
		.localNode(port0Node)
	) port0 (
		.clk(clk),
		.reset(reset),
		.req(req0),
		.request(request0),
		.ack(ack0),
		.readData(readData0),
		.injectFlit(hostIn[port0Node]),
		.injectBusy(hostInBusy[port0Node]),
		.responseFlit(hostOut[port0Node]),
		.responseBusy(hostOutBusy[port0Node])
	);

	accessPort #(
		.localNode(port1Node)
	) port1 (
		.clk(clk),
		.reset(reset),
		.req(req1),
		.request(request1),
		.ack(ack1),
		.readData(readData1),
		.injectFlit(hostIn[port1Node]),
		.injectBusy(hostInBusy[port1Node]),
		.responseFlit(hostOut[port1Node]),
		.responseBusy(hostOutBusy[port1Node])
	);

endmodule

//--- verif/meshNetwork_assertions.sv
// Host handshake checks
`timescale 1ns/1ps

module handshakeChecks (
	input logic clk,
	input logic reset,
	input logic req0,
	input logic ack0,
	input cachePkg::word readData0,
	input logic req1,
	input logic ack1,
	input cachePkg::word readData1
);

	// Failed handshake properties
	int failCount = 0;

	// Ack rises in a cycle where req was high
	ackRise0: assert property (@(posedge clk) disable iff (reset) $rose(ack0) |-> $past(req0))
		else begin
			failCount++;
			$error("ack0 rose while req0 was low");
		end
	ackRise1: assert property (@(posedge clk) disable iff (reset) $rose(ack1) |-> $past(req1))
		else begin
			failCount++;
			$error("ack1 rose while req1 was low");
		end

	ackFall0: assert property (@(posedge clk) disable iff (reset) $fell(ack0) |-> !$past(req0))
		else begin
			failCount++;
			$error("ack0 fell while req0 was still high");
		end
	ackFall1: assert property (@(posedge clk) disable iff (reset) $fell(ack1) |-> !$past(req1))
		else begin
			failCount++;
			$error("ack1 fell while req1 was still high");
		end

	dataHold0: assert property (@(posedge clk) disable iff (reset)
		ack0 && $past(ack0) |-> $stable(readData0))
		else begin
			failCount++;
			$error("readData0 changed while ack0 was high");
		end
	dataHold1: assert property (@(posedge clk) disable iff (reset)
		ack1 && $past(ack1) |-> $stable(readData1))
		else begin
			failCount++;
			$error("readData1 changed while ack1 was high");
		end

endmodule

bind meshNetwork handshakeChecks handshake (
	.clk(clk),
	.reset(reset),
	.req0(req0),
	.ack0(ack0),
	.readData0(readData0),
	.req1(req1),
	.ack1(ack1),
	.readData1(readData1)
);

//--- verif/meshNetworkTb.sv
// Mesh cache testbench
`timescale 1ns/1ps

module meshNetworkTb;

	localparam int networkHeight = 3;
	localparam int networkWidth = 3;
	localparam int nodeCount = networkHeight * networkWidth;
	localparam int bankWords = 16;
	localparam int halfWords = bankWords / 2;
	localparam int port0Node = networkWidth / 2;
	localparam int port1Node = (networkHeight - 1) * networkWidth + networkWidth / 2 - 1;
	localparam int randomCount = 200;
	localparam int directedCount = 9;
	localparam int cyclesPerTransaction = 50;
	localparam int timeoutCycles = 2 * (randomCount + directedCount) * cyclesPerTransaction;

	logic clk;
	logic reset;
	logic req0;
	logic req1;
	cachePkg::hostRequest request0;
	cachePkg::hostRequest request1;
	logic ack0;
	logic ack1;
	cachePkg::word readData0;
	cachePkg::word readData1;

	cachePkg::word model [nodeCount][bankWords];
	// Word before the latest write
	cachePkg::word prevModel [nodeCount][bankWords];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	meshNetwork #(
		.networkHeight(networkHeight),
		.networkWidth(networkWidth)
	) DUT (
		.clk(clk),
		.reset(reset),
		.req0(req0),
		.request0(request0),
		.ack0(ack0),
		.readData0(readData0),
		.req1(req1),
		.request1(request1),
		.ack1(ack1),
		.readData1(readData1)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic ackFor(input int port);
		return (port == 0) ? ack0 : ack1;
	endfunction

	task automatic driveReq(input int port, input logic level, input cachePkg::hostRequest r);
		if (port == 0) begin
			request0 = r;
			req0 = level;
		end else begin
			request1 = r;
			req1 = level;
		end
	endtask

	task automatic expectZero(input string name, input cachePkg::word got);
		checkCount++;
		assert (got == '0) else begin
			errorCount++;
			$display("Mismatch at %0t: %s expected 0, got %h", $time, name, got);
		end
	endtask

	// One four-phase transaction, checked against the model
	task automatic transact(input int port, input cachePkg::memOp op, input int node,
		input int addr, input cachePkg::word data);
		cachePkg::hostRequest r;
		cachePkg::word got;
		cachePkg::word expected;
		logic raced;
		r = '{op: op, node: cachePkg::nodeId'(node), bankAddr: 4'(addr), data: data};
		@(posedge clk);
		#1;
		if (op == cachePkg::opWrite) begin
			prevModel[node][addr] = model[node][addr];
			model[node][addr] = data;
		end
		driveReq(port, 1'b1, r);
		do begin
			@(posedge clk);
			#1;
		end while (!ackFor(port));
		got = (port == 0) ? readData0 : readData1;
		expected = (op == cachePkg::opWrite) ? data : model[node][addr];
		// The other port may write its half while this read travels
		raced = op == cachePkg::opRead && (addr / halfWords) != port
			&& got == prevModel[node][addr];
		checkCount++;
		assert (got == expected || raced) else begin
			errorCount++;
			$display("Mismatch at %0t: readData%0d expected %h, got %h",
				$time, port, expected, got);
		end
		driveReq(port, 1'b0, r);
		do begin
			@(posedge clk);
			#1;
		end while (ackFor(port));
	endtask

	task automatic runPort(input int port);
		int targets [3];
		int cornerRow;
		int base;
		int node;
		int addr;
		cachePkg::word data;
		cornerRow = (port == 0) ? networkHeight - 1 : 0;
		targets[0] = (port == 0) ? port0Node : port1Node;
		targets[1] = cornerRow * networkWidth;
		targets[2] = cornerRow * networkWidth + networkWidth - 1;
		base = port * halfWords;
		// Home node and far corners: fresh read, write, read back
		for (int t = 0; t < 3; t++) begin
			addr = base + t + 1;
			data = cachePkg::word'($urandom);
			transact(port, cachePkg::opRead, targets[t], addr, '0);
			transact(port, cachePkg::opWrite, targets[t], addr, data);
			transact(port, cachePkg::opRead, targets[t], addr, '0);
		end
		for (int k = 0; k < randomCount; k++) begin
			node = $urandom_range(nodeCount - 1);
			data = cachePkg::word'($urandom);
			if ($urandom_range(1) == 1) begin
				addr = base + $urandom_range(halfWords - 1);
				transact(port, cachePkg::opWrite, node, addr, data);
			end else begin
				addr = $urandom_range(bankWords - 1);
				transact(port, cachePkg::opRead, node, addr, '0);
			end
			repeat ($urandom_range(3)) @(posedge clk);
		end
	endtask

	initial begin
		void'($urandom(26347));
		reset = 1'b1;
		req0 = 1'b0;
		req1 = 1'b0;
		request0 = '0;
		request1 = '0;
		for (int n = 0; n < nodeCount; n++) begin
			for (int a = 0; a < bankWords; a++) begin
				model[n][a] = '0;
				prevModel[n][a] = '0;
			end
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		expectZero("ack0", cachePkg::word'(ack0));
		expectZero("ack1", cachePkg::word'(ack1));
		expectZero("readData0", readData0);
		expectZero("readData1", readData1);
		fork
			runPort(0);
			runPort(1);
		join
		errorCount += DUT.handshake.failCount;
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- src.f
logic/cachePkg.sv
logic/meshPkg.sv
logic/cacheBank.sv
logic/meshRouter.sv
logic/accessPort.sv
logic/meshNetwork.sv
verif/meshNetwork_assertions.sv
verif/meshNetworkTb.sv
